//--- hist_defines.svh
`ifndef HIST_DEFINES_SVH
`define HIST_DEFINES_SVH

// bin number width, 16 bins by default
`define BIN_BITS 4

// width of one bin count
// counts stick at all ones
`define COUNT_BITS 8

// pixels handled per pass
`define PIXEL_NUM 4

// hits taken for a pixel before moving on
`define HITS_PER_PIXEL 3

// acquisitions per pass
// each one walks every pixel once
`define ACQ_NUM 2

`endif

//--- hist_pkg.sv
`default_nettype none

`include "hist_defines.svh"

package hist_pkg;

    // pixel index width, never below one bit
    localparam int PIXEL_BITS = (`PIXEL_NUM > 1) ? $clog2(`PIXEL_NUM) : 1;

    // bin number of a hit
    typedef logic [`BIN_BITS-1:0] bin_t;

    // count held per pixel and bin
    typedef logic [`COUNT_BITS-1:0] count_t;

    // pixel index inside a pass
    typedef logic [PIXEL_BITS-1:0] pixel_t;

    // builder fsm
    // counting takes hits, clearing sweeps the count memory
    typedef enum logic {
        COUNTING = 1'b0,
        CLEARING = 1'b1
    } builder_state_t;

endpackage

`default_nettype wire

//--- hist_update_if.sv
`timescale 1ns/1ns
`default_nettype none

interface hist_update_if;
    import hist_pkg::*;

    // one-cycle strobe per counted hit
    logic   upd_valid;
    // where the hit landed
    pixel_t upd_pixel;
    bin_t   upd_bin;
    // bin count after the increment
    count_t upd_count;
    // final update of the pass
    logic   upd_last;
    // pass level, 0 coarse and 1 fine
    logic   pass_sel;

    // builder drives everything
    modport builder (
        output upd_valid,
        output upd_pixel,
        output upd_bin,
        output upd_count,
        output upd_last,
        output pass_sel
    );

    // tracker only listens
    modport tracker (
        input upd_valid,
        input upd_pixel,
        input upd_bin,
        input upd_count,
        input upd_last,
        input pass_sel
    );

endinterface

`default_nettype wire

//--- hist_builder.sv
`timescale 1ns/1ns
`default_nettype none

`include "hist_defines.svh"

module hist_builder (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               hit_valid,
    input  hist_pkg::bin_t     hit_bin,
    hist_update_if.builder     upd,
    output logic               pass_done,
    output logic               busy
);
    import hist_pkg::*;

    // counter widths, at least one bit each
    localparam int HIT_BITS  = (`HITS_PER_PIXEL > 1) ? $clog2(`HITS_PER_PIXEL) : 1;
    localparam int ACQ_BITS  = (`ACQ_NUM > 1) ? $clog2(`ACQ_NUM) : 1;
    // memory is pixel major, one word per bin
    localparam int ADDR_BITS = PIXEL_BITS + `BIN_BITS;
    localparam int MEM_WORDS = `PIXEL_NUM * (2 ** `BIN_BITS);

    // wrap points of the nested counters
    localparam logic [HIT_BITS-1:0]  HIT_LAST   = HIT_BITS'(`HITS_PER_PIXEL - 1);
    localparam pixel_t               PIXEL_LAST = PIXEL_BITS'(`PIXEL_NUM - 1);
    localparam logic [ACQ_BITS-1:0]  ACQ_LAST   = ACQ_BITS'(`ACQ_NUM - 1);
    localparam logic [ADDR_BITS-1:0] CLR_LAST   = ADDR_BITS'(MEM_WORDS - 1);

    // count memory
    count_t                 mem [MEM_WORDS];
    // word written since reset
    // unwritten words read as zero, so reset needs no sweep
    logic [MEM_WORDS-1:0]   word_vld;

    builder_state_t         state;
    logic [HIT_BITS-1:0]    hit_cnt;
    pixel_t                 pixel;
    logic [ACQ_BITS-1:0]    acq;
    logic [ADDR_BITS-1:0]   clr_addr;
    logic                   sel_q;

    logic                   hit_acc;
    logic                   pass_end;
    logic [ADDR_BITS-1:0]   wr_addr;
    count_t                 cur_count;
    count_t                 next_count;

    // hits only while counting
    assign busy    = (state == CLEARING);
    assign hit_acc = hit_valid && (state == COUNTING);

    // last hit of last pixel of last acquisition
    assign pass_end = (hit_cnt == HIT_LAST) && (pixel == PIXEL_LAST) && (acq == ACQ_LAST);

    // pixel picks the block, bin the word in it
    assign wr_addr = {pixel, hit_bin};

    // read, then increment unless already at full scale
    always_comb begin
        cur_count  = word_vld[wr_addr] ? mem[wr_addr] : '0;
        next_count = (cur_count == '1) ? cur_count : cur_count + 1'b1;
    end

    // memory port, one write per cycle
    always_ff @(posedge clk) begin
        if (state == CLEARING) begin
            mem[clr_addr] <= '0;
        end else if (hit_acc) begin
            mem[wr_addr] <= next_count;
        end
    end

    // update payload, only looked at with upd_valid
    always_ff @(posedge clk) begin
        if (hit_acc) begin
            upd.upd_pixel <= pixel;
            upd.upd_bin   <= hit_bin;
            upd.upd_count <= next_count;
        end
    end

    // fsm, nested counters and pass strobes
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state         <= COUNTING;
            hit_cnt       <= '0;
            pixel         <= '0;
            acq           <= '0;
            clr_addr      <= '0;
            sel_q         <= 1'b0;
            word_vld      <= '0;
            upd.upd_valid <= 1'b0;
            upd.upd_last  <= 1'b0;
        end else begin
            // update shows one cycle after the hit
            upd.upd_valid <= hit_acc;
            upd.upd_last  <= hit_acc && pass_end;

            case (state)
                COUNTING: begin
                    if (hit_acc) begin
                        word_vld[wr_addr] <= 1'b1;
                        // hits inside pixel, pixels inside acquisition
                        if (hit_cnt == HIT_LAST) begin
                            hit_cnt <= '0;
                            if (pixel == PIXEL_LAST) begin
                                pixel <= '0;
                                if (acq == ACQ_LAST) begin
                                    acq <= '0;
                                end else begin
                                    acq <= acq + 1'b1;
                                end
                            end else begin
                                pixel <= pixel + 1'b1;
                            end
                        end else begin
                            hit_cnt <= hit_cnt + 1'b1;
                        end
                        // pass over, go wipe the histogram
                        if (pass_end) begin
                            state    <= CLEARING;
                            clr_addr <= '0;
                        end
                    end
                end

                CLEARING: begin
                    // one word per cycle
                    clr_addr <= clr_addr + 1'b1;
                    if (clr_addr == CLR_LAST) begin
                        // sweep done, swap coarse and fine
                        state <= COUNTING;
                        sel_q <= ~sel_q;
                    end
                end

                default: begin
                    state <= COUNTING;
                end
            endcase
        end
    end

    // pass level stays put through the sweep
    assign upd.pass_sel = sel_q;

    // pass end strobe is the last update
    assign pass_done = upd.upd_last;

endmodule

`default_nettype wire

//--- peak_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module peak_tracker (
    input  logic               clk,
    input  logic               combin_res,
    hist_update_if.tracker     upd,
    output hist_pkg::bin_t     peak_coarse,
    output hist_pkg::bin_t     peak_fine,
    output logic               peak_done
);
    import hist_pkg::*;

    // running maximum over the whole pass
    count_t run_max;
    bin_t   run_bin;

    // maximum after looking at the current update
    logic   take;
    count_t cand_max;
    bin_t   cand_bin;

    // fine peak written last cycle
    logic   fine_wr;

    logic   last_upd;

    assign last_upd = upd.upd_valid && upd.upd_last;

    // strictly greater only
    // a tie keeps the bin that got there first
    always_comb begin
        take     = upd.upd_valid && (upd.upd_count > run_max);
        cand_max = take ? upd.upd_count : run_max;
        cand_bin = take ? upd.upd_bin : run_bin;
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            run_max     <= '0;
            run_bin     <= '0;
            peak_coarse <= '0;
            peak_fine   <= '0;
            fine_wr     <= 1'b0;
            peak_done   <= 1'b0;
        end else begin
            // done strobe trails the fine peak by a cycle
            fine_wr   <= last_upd && upd.pass_sel;
            peak_done <= fine_wr;

            if (last_upd) begin
                // pass level picks the register
                if (upd.pass_sel) begin
                    peak_fine <= cand_bin;
                end else begin
                    peak_coarse <= cand_bin;
                end
                // fresh start for the next pass
                run_max <= '0;
                run_bin <= '0;
            end else begin
                run_max <= cand_max;
                run_bin <= cand_bin;
            end
        end
    end

endmodule

`default_nettype wire

//--- tof_hist_top.sv
`timescale 1ns/1ns
`default_nettype none

module tof_hist_top (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               hit_valid,
    input  hist_pkg::bin_t     hit_bin,
    output logic               bin_valid,
    output hist_pkg::count_t   bin_count,
    output logic               pass_done,
    output logic               pass_sel,
    output logic               busy,
    output hist_pkg::bin_t     peak_coarse,
    output hist_pkg::bin_t     peak_fine,
    output logic               peak_done
);

    // builder to tracker update path
    hist_update_if u_upd ();

    // histogram memory and pass control
    hist_builder u_builder (
        .clk        (clk),
        .combin_res (combin_res),
        .hit_valid  (hit_valid),
        .hit_bin    (hit_bin),
        .upd        (u_upd.builder),
        .pass_done  (pass_done),
        .busy       (busy)
    );

    // peak search per pass
    peak_tracker u_tracker (
        .clk         (clk),
        .combin_res  (combin_res),
        .upd         (u_upd.tracker),
        .peak_coarse (peak_coarse),
        .peak_fine   (peak_fine),
        .peak_done   (peak_done)
    );

    // last updated count goes out as is
    assign bin_valid = u_upd.upd_valid;
    assign bin_count = u_upd.upd_count;
    assign pass_sel  = u_upd.pass_sel;

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
    // half of the 4 ns period
    parameter int HALF_PERIOD = 2
) (
    output logic clk
);

    // free running, first rising edge at 2 ns
    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- tb_tof_hist.sv
`timescale 1ns/1ns
`default_nettype none

`include "hist_defines.svh"

module tb_tof_hist;
    import hist_pkg::*;

    localparam int DRIVE_DELAY = 1;
    localparam int WAIT_LIMIT  = 400;
    localparam int WATCHDOG_NS = 100000;
    localparam int NUM_BINS    = 2 ** `BIN_BITS;
    localparam int PASS_HITS   = `PIXEL_NUM * `HITS_PER_PIXEL * `ACQ_NUM;
    localparam int SWEEP_LEN   = `PIXEL_NUM * NUM_BINS;
    localparam int COUNT_MAX   = (2 ** `COUNT_BITS) - 1;
    // event selectors for the wait loop
    localparam int EV_PASS_DONE = 0;
    localparam int EV_PEAK_DONE = 1;
    localparam int EV_IDLE      = 2;

    logic   clk;
    logic   combin_res;
    logic   hit_valid;
    bin_t   hit_bin;
    logic   bin_valid;
    count_t bin_count;
    logic   pass_done;
    logic   pass_sel;
    logic   busy;
    bin_t   peak_coarse;
    bin_t   peak_fine;
    logic   peak_done;

    // bookkeeping
    string  test_name = "startup";
    int     error_count = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     pdone_seen = 0;
    logic [15:0] lfsr = 16'd46;

    // reference model state
    int     m_count [`PIXEL_NUM][NUM_BINS];
    // position inside the pass
    int     m_hit;
    int     m_pix;
    int     m_acq;
    int     c;
    // first to maximum over the pass
    int     run_max;
    bin_t   run_bin;
    // sweep and peak timing
    int     busy_left;
    int     peak_wait;
    bin_t   pend_bin;
    logic   pend_fine;
    bin_t   m_peak_coarse;
    bin_t   m_peak_fine;
    logic   m_sel;
    logic   m_busy;
    logic   m_busy_q;
    logic   pdone_next;
    logic   exp_pdone;
    // expected update for the coming edge
    logic   exp_valid;
    logic   exp_done;
    count_t exp_count;

    tb_clk_gen u_clk (.clk(clk));

    tof_hist_top u_dut (
        .clk         (clk),
        .combin_res  (combin_res),
        .hit_valid   (hit_valid),
        .hit_bin     (hit_bin),
        .bin_valid   (bin_valid),
        .bin_count   (bin_count),
        .pass_done   (pass_done),
        .pass_sel    (pass_sel),
        .busy        (busy),
        .peak_coarse (peak_coarse),
        .peak_fine   (peak_fine),
        .peak_done   (peak_done)
    );

    // 16 bit fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    function logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic report_wrong_value(input string what, input int exp_val, input int act_val);
        error_count++;
        $display("MISMATCH %s: %s expected %0d actual %0d", test_name, what, exp_val, act_val);
    endtask

    task automatic flag_error(input string what);
        error_count++;
        $display("check failed in %s: %s", test_name, what);
    endtask

    // timing rules checked on every rising edge
    a_hit_latency: assert property (@(posedge clk) disable iff (!combin_res)
        (hit_valid && !busy) |=> bin_valid)
        else flag_error("accepted hit gave no bin_valid one cycle later");
    a_no_stray: assert property (@(posedge clk) disable iff (!combin_res)
        !(hit_valid && !busy) |=> !bin_valid)
        else flag_error("bin_valid without an accepted hit, hit during busy not dropped");
    a_done_busy: assert property (@(posedge clk) disable iff (!combin_res)
        pass_done |-> (busy && !$past(busy)))
        else flag_error("pass_done not aligned with the rise of busy");
    a_done_pulse: assert property (@(posedge clk) disable iff (!combin_res)
        pass_done |=> !pass_done)
        else flag_error("pass_done longer than one cycle");
    a_peak_fine: assert property (@(posedge clk) disable iff (!combin_res)
        peak_done |-> (busy && pass_sel))
        else flag_error("peak_done outside a fine pass sweep");
    a_peak_pulse: assert property (@(posedge clk) disable iff (!combin_res)
        peak_done |=> !peak_done)
        else flag_error("peak_done longer than one cycle");

    task automatic model_reset();
        foreach (m_count[p, b]) begin
            m_count[p][b] = 0;
        end
        m_hit = 0;
        m_pix = 0;
        m_acq = 0;
        run_max = 0;
        run_bin = '0;
        busy_left = 0;
        peak_wait = 0;
        m_sel = 1'b0;
        m_busy_q = 1'b0;
        pdone_next = 1'b0;
        m_peak_coarse = '0;
        m_peak_fine = '0;
        exp_valid = 1'b0;
        exp_done = 1'b0;
    endtask

    // reference model stepped on the falling edge
    always @(negedge clk) begin
        if (!combin_res) begin
            model_reset();
        end else begin
            // pass level flips as the sweep ends
            m_busy = (busy_left > 0);
            if (m_busy_q && !m_busy) begin
                m_sel = ~m_sel;
            end
            m_busy_q = m_busy;
            if (busy_left > 0) begin
                busy_left--;
            end
            // peak lands two edges after the last hit and done one edge later
            exp_pdone = pdone_next;
            pdone_next = 1'b0;
            if (peak_wait > 0) begin
                peak_wait--;
                if (peak_wait == 0) begin
                    if (pend_fine) begin
                        m_peak_fine = pend_bin;
                        pdone_next = 1'b1;
                    end else begin
                        m_peak_coarse = pend_bin;
                    end
                end
            end
            if (peak_done) begin
                pdone_seen++;
            end

            assert (bin_valid == exp_valid)
                else report_wrong_value("bin_valid", exp_valid, bin_valid);
            if (exp_valid) begin
                assert (bin_count == exp_count)
                    else report_wrong_value("bin_count", int'(exp_count), int'(bin_count));
            end
            assert (pass_done == exp_done)
                else report_wrong_value("pass_done", exp_done, pass_done);
            assert (busy == m_busy) else report_wrong_value("busy", m_busy, busy);
            assert (pass_sel == m_sel) else report_wrong_value("pass_sel", m_sel, pass_sel);
            assert (peak_done == exp_pdone)
                else report_wrong_value("peak_done", exp_pdone, peak_done);
            assert (peak_coarse == m_peak_coarse)
                else report_wrong_value("peak_coarse", int'(m_peak_coarse), int'(peak_coarse));
            assert (peak_fine == m_peak_fine)
                else report_wrong_value("peak_fine", int'(m_peak_fine), int'(peak_fine));

            // hit presented now is taken at the coming edge
            exp_valid = 1'b0;
            exp_done = 1'b0;
            if (hit_valid && !m_busy) begin
                c = m_count[m_pix][hit_bin];
                if (c < COUNT_MAX) begin
                    c++;
                end
                m_count[m_pix][hit_bin] = c;
                exp_valid = 1'b1;
                exp_count = count_t'(c);
                // strictly greater so the first to reach keeps it
                if (c > run_max) begin
                    run_max = c;
                    run_bin = hit_bin;
                end
                m_hit++;
                if (m_hit == `HITS_PER_PIXEL) begin
                    m_hit = 0;
                    m_pix++;
                    if (m_pix == `PIXEL_NUM) begin
                        m_pix = 0;
                        m_acq++;
                    end
                end
                if (m_acq == `ACQ_NUM) begin
                    // pass complete
                    m_acq = 0;
                    exp_done = 1'b1;
                    busy_left = SWEEP_LEN;
                    peak_wait = 2;
                    pend_bin = run_bin;
                    pend_fine = m_sel;
                    run_max = 0;
                    run_bin = '0;
                    foreach (m_count[p, b]) begin
                        m_count[p][b] = 0;
                    end
                end
            end
        end
    end

    // next drive point a little after the rising edge
    task automatic tick();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic finish_test(input int start_err);
        tests_run++;
        if (error_count == start_err) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, error_count - start_err);
        end
    endtask

    // poll one dut output per cycle up to the limit
    task automatic wait_for_event(input int which, input string what, input logic hitting);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < WAIT_LIMIT && !seen; i++) begin
            case (which)
                EV_PASS_DONE: seen = pass_done;
                EV_PEAK_DONE: seen = peak_done;
                default:      seen = !busy;
            endcase
            if (!seen) begin
                hit_valid = hitting;
                hit_bin = bin_t'(take_bits(`BIN_BITS));
                tick();
            end
        end
        if (!seen) begin
            error_count++;
            $display("timeout in %s: %s not seen within %0d cycles", test_name, what, WAIT_LIMIT);
        end
    endtask

    task automatic check_reset_state();
        assert (!busy) else report_wrong_value("busy", 0, busy);
        assert (!pass_done) else report_wrong_value("pass_done", 0, pass_done);
        assert (!bin_valid) else report_wrong_value("bin_valid", 0, bin_valid);
        assert (!peak_done) else report_wrong_value("peak_done", 0, peak_done);
        assert (!pass_sel) else report_wrong_value("pass_sel", 0, pass_sel);
        assert (peak_coarse == '0) else report_wrong_value("peak_coarse", 0, int'(peak_coarse));
        assert (peak_fine == '0) else report_wrong_value("peak_fine", 0, int'(peak_fine));
    endtask

    // one full pass with hits leaning toward the bias bin
    task automatic run_pass(input string name, input bin_t bias);
        int hits;
        int start_err;
        int start_pdone;
        logic fine;
        logic [7:0] r;
        test_name = name;
        start_err = error_count;
        start_pdone = pdone_seen;
        fine = pass_sel;
        hits = 0;
        while (hits < PASS_HITS) begin
            r = take_bits(3);
            if (r[2:1] == 2'b00) begin
                hit_valid = 1'b0;
            end else begin
                hit_valid = 1'b1;
                hit_bin = r[0] ? bias : bin_t'(take_bits(`BIN_BITS));
                hits++;
            end
            tick();
        end
        // keep hitting into the sweep where all of it is dropped
        wait_for_event(EV_PASS_DONE, "pass_done", 1'b1);
        if (fine) begin
            wait_for_event(EV_PEAK_DONE, "peak_done", 1'b1);
        end
        repeat (6) begin
            hit_valid = 1'b1;
            hit_bin = bin_t'(take_bits(`BIN_BITS));
            tick();
        end
        hit_valid = 1'b0;
        wait_for_event(EV_IDLE, "end of clear sweep", 1'b0);
        tick();
        assert (pdone_seen - start_pdone == (fine ? 1 : 0))
            else report_wrong_value("peak_done pulses", fine ? 1 : 0, pdone_seen - start_pdone);
        finish_test(start_err);
    endtask

    initial begin
        int start_err;
        combin_res = 1'b0;
        hit_valid = 1'b0;
        hit_bin = '0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        combin_res = 1'b1;

        test_name = "reset_state";
        start_err = error_count;
        check_reset_state();
        finish_test(start_err);
        tick();

        // two coarse and fine rounds
        run_pass("coarse_pass_1", bin_t'(5));
        run_pass("fine_pass_1", bin_t'(11));
        run_pass("coarse_pass_2", bin_t'(2));
        run_pass("fine_pass_2", bin_t'(14));

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // last line of defence against a stuck run
    initial begin
        #WATCHDOG_NS;
        $display("watchdog expired in %s, run did not finish", test_name);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
hist_pkg.sv
hist_update_if.sv
hist_builder.sv
peak_tracker.sv
tof_hist_top.sv
tb_clk_gen.sv
tb_tof_hist.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= tb_tof_hist
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module tof_hist_top -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
